// ==== design/gfx_rom_arb.sv ====
// round-robin arbiter sharing the graphics rom port between the two draw engines
`timescale 1ns/1ns
module gfx_rom_arb (
    input  logic                clk,
    input  logic                rst,
    input  logic                req_cs0,
    input  obj_pkg::rom_addr_t  req_addr0,
    input  obj_pkg::bank_t      req_bank0,
    input  logic                req_half0,
    input  logic                req_cs1,
    input  obj_pkg::rom_addr_t  req_addr1,
    input  obj_pkg::bank_t      req_bank1,
    input  logic                req_half1,
    output obj_pkg::rom_data_t  grant_data0,
    output logic                grant_ok0,
    output obj_pkg::rom_data_t  grant_data1,
    output logic                grant_ok1,
    output obj_pkg::rom_addr_t  rom_addr,
    output obj_pkg::bank_t      rom_bank,
    output logic                rom_half,
    output logic                rom_cs,
    input  obj_pkg::rom_data_t  rom_data,
    input  logic                rom_ok
);

    logic       owner;     // last granted engine
    logic       owned;     // grant active
    logic [1:0] settle;    // masks ok left over from the previous owner
    logic       owner_cs;
    logic       other_cs;
    logic       ok;

    assign owner_cs = owner ? req_cs1 : req_cs0;
    assign other_cs = owner ? req_cs0 : req_cs1;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            owner  <= 1'b0;
            owned  <= 1'b0;
            settle <= '0;
        end else begin
            settle <= settle >> 1;
            if (!owned || !owner_cs) begin  // free or just released
                if (other_cs) begin
                    owner  <= ~owner;  // other side first
                    owned  <= 1'b1;
                    settle <= 2'b11;
                end else if (owner_cs) begin
                    owned  <= 1'b1;
                    settle <= 2'b11;
                end else begin
                    owned <= 1'b0;
                end
            end
        end
    end

    assign rom_cs   = owned && owner_cs;  // 0 when nothing granted
    assign rom_addr = owner ? req_addr1 : req_addr0;
    assign rom_bank = owner ? req_bank1 : req_bank0;
    assign rom_half = owner ? req_half1 : req_half0;

    assign ok          = rom_cs && rom_ok && settle == 2'b00;
    assign grant_ok0   = ok && !owner;
    assign grant_ok1   = ok && owner;
    assign grant_data0 = owner ? '0 : rom_data;
    assign grant_data1 = owner ? rom_data : '0;

    // two waiting engines never leave the port idle
    a_no_idle_port: assert property (@(posedge clk) disable iff (rst)
        (req_cs0 && req_cs1) |-> rom_cs);

endmodule

// ==== design/obj_draw.sv ====
// sprite draw engine, fetches both rom halves of one object row and writes 16 pixels to the line buffer
`timescale 1ns/1ns
module obj_draw (
    input  logic                clk,
    input  logic                rst,
    input  obj_pkg::code_t      obj_code,
    input  obj_pkg::attr_t      obj_attr,
    input  obj_pkg::hpos_t      obj_hpos,
    input  obj_pkg::bank_t      obj_bank,
    input  logic                start,
    output logic                idle,
    output obj_pkg::hpos_t      buf_addr,
    output obj_pkg::pxl_t       buf_data,
    output logic                buf_wr,
    output obj_pkg::rom_addr_t  rom_addr,
    output obj_pkg::bank_t      rom_bank,
    output logic                rom_half,
    input  obj_pkg::rom_data_t  rom_data,
    output logic                rom_cs,
    input  logic                rom_ok
);

    logic [1:0]         wait_cycle;  // ok is stale for two cycles after an address change
    logic               draw;
    logic [3:0]         cnt;         // 8 writes, then one idle cycle
    logic               second;      // working on the second half
    logic               hflip;
    logic [4:0]         pal;
    obj_pkg::hpos_t     pos;         // next buffer address
    obj_pkg::rom_data_t pxl_data;
    logic               rom_good;
    logic               put;
    logic               half_end;
    logic [3:0]         nib;

    assign rom_good = !idle && !draw && rom_ok && wait_cycle == 2'b00;
    assign put      = draw && !cnt[3];
    assign half_end = (draw && cnt[3]) || (rom_good && &rom_data);  // drawn or blank
    assign nib      = hflip ? pxl_data[3:0] : pxl_data[31:28];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            idle       <= 1'b1;
            rom_cs     <= 1'b0;
            buf_wr     <= 1'b0;
            draw       <= 1'b0;
            cnt        <= '0;
            second     <= 1'b0;
            wait_cycle <= '0;
        end else begin
            wait_cycle <= wait_cycle >> 1;
            buf_wr     <= put;
            if (idle && start) begin
                idle       <= 1'b0;
                rom_cs     <= 1'b1;  // held across both halves
                second     <= 1'b0;
                wait_cycle <= 2'b11;
            end
            if (rom_good && !(&rom_data)) begin
                draw <= 1'b1;
                cnt  <= '0;
            end
            if (put) begin
                cnt <= cnt + 4'd1;
            end
            if (half_end) begin
                draw <= 1'b0;
                if (second) begin
                    idle   <= 1'b1;  // last write already out
                    rom_cs <= 1'b0;  // lets the arbiter move on
                end else begin
                    second     <= 1'b1;
                    wait_cycle <= 2'b11;  // rom_half flips below
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (idle && start) begin
            rom_addr <= {obj_code, obj_attr[11:8]};
            rom_bank <= obj_bank;
            rom_half <= obj_attr[5];  // flipped objects start on the right half
            hflip    <= obj_attr[5];
            pal      <= obj_attr[4:0];
            pos      <= obj_hpos;
        end
        if (rom_good) begin
            pxl_data <= rom_data;
        end
        if (put) begin
            buf_addr <= pos;
            buf_data <= {pal, nib};
            pos      <= pos + 9'd1;
            // refill with ones so a stray read stays transparent
            pxl_data <= hflip ? {4'hF, pxl_data[31:4]} : {pxl_data[27:0], 4'hF};
        end
        if (rom_good && &rom_data) begin
            pos <= pos + 9'd8;  // blank half, no writes
        end
        if (half_end && !second) begin
            rom_half <= ~rom_half;
        end
    end

    a_no_wr_idle: assert property (@(posedge clk) disable iff (rst) idle |-> !buf_wr);

endmodule

// ==== design/obj_line_buf.sv ====
// 512-pixel sprite line buffer, two write ports dropping transparent pixels, clear-on-read scan-out
`timescale 1ns/1ns
module obj_line_buf (
    input  logic            clk,
    input  logic            rst,
    input  logic            wr0,
    input  obj_pkg::hpos_t  wa0,
    input  obj_pkg::pxl_t   wd0,
    input  logic            wr1,
    input  obj_pkg::hpos_t  wa1,
    input  obj_pkg::pxl_t   wd1,
    input  logic            rd_en,
    input  obj_pkg::hpos_t  rd_addr,
    output obj_pkg::pxl_t   rd_data
);

    obj_pkg::pxl_t mem [obj_pkg::LINE_LEN];
    logic          keep0;
    logic          keep1;

    assign keep0 = wr0 && wd0[3:0] != obj_pkg::TRANSPARENT;
    assign keep1 = wr1 && wd1[3:0] != obj_pkg::TRANSPARENT;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < obj_pkg::LINE_LEN; i++) begin
                mem[i] <= '1;  // whole line transparent
            end
            rd_data <= '1;
        end else begin
            if (rd_en) begin
                rd_data      <= mem[rd_addr];
                mem[rd_addr] <= '1;  // ready for the next line
            end
            if (keep1) begin
                mem[wa1] <= wd1;
            end
            if (keep0) begin
                mem[wa0] <= wd0;  // last assignment, port 0 wins a tie
            end
        end
    end

endmodule

// ==== design/obj_pkg.sv ====
// shared widths, typedefs and constants of the sprite line renderer, used as obj_pkg::name
package obj_pkg;

    typedef logic [15:0] word_t;      // one host table word
    typedef logic [15:0] code_t;      // tile code
    typedef logic [15:0] attr_t;      // [14:13] bank, [11:8] row, [5] hflip, [4:0] palette
    typedef logic [8:0]  hpos_t;      // horizontal position, also line buffer index
    typedef logic [8:0]  vpos_t;      // line number or object top
    typedef logic [1:0]  bank_t;
    typedef logic [19:0] rom_addr_t;  // {code, row}
    typedef logic [31:0] rom_data_t;  // 8 pixels of 4 bits
    typedef logic [8:0]  pxl_t;       // {palette, colour}
    typedef logic [6:0]  tbl_addr_t;  // {entry, word}

    localparam int OBJ_MAX   = 32;           // table entries
    localparam int TBL_DEPTH = OBJ_MAX * 4;  // four words per entry
    localparam int LINE_LEN  = 512;

    localparam word_t      TBL_END_ATTR = 16'hFF00;  // attr value that stops the scan
    localparam hpos_t      HPOS_MIN     = 9'h30;     // exclusive bounds
    localparam hpos_t      HPOS_MAX     = 9'h1C0;
    localparam logic [3:0] TRANSPARENT  = 4'hF;

    // scanner fsm
    typedef enum logic [2:0] {
        SCAN_IDLE,
        SCAN_RD,     // four word reads
        SCAN_TEST,   // attr arrives, range test
        SCAN_ISSUE,
        SCAN_WAIT    // both engines busy
    } scan_state_t;

endpackage

// ==== design/obj_render_top.sv ====
// sprite layer renderer top, wires the table, scanner, two draw engines, rom arbiter and line buffer
`timescale 1ns/1ns
module obj_render_top (
    input  logic                clk,
    input  logic                rst,
    input  logic                tbl_we,
    input  obj_pkg::tbl_addr_t  tbl_addr,
    input  obj_pkg::word_t      tbl_data,
    input  logic                line_start,
    input  obj_pkg::vpos_t      line,
    output logic                line_done,
    input  logic                rd_en,
    input  obj_pkg::hpos_t      rd_addr,
    output obj_pkg::pxl_t       rd_data,
    output obj_pkg::rom_addr_t  rom_addr,
    output obj_pkg::bank_t      rom_bank,
    output logic                rom_half,
    output logic                rom_cs,
    input  obj_pkg::rom_data_t  rom_data,
    input  logic                rom_ok
);

    obj_pkg::tbl_addr_t scn_addr;
    obj_pkg::word_t     scn_data;
    obj_pkg::code_t     obj_code;   // shared by both engines
    obj_pkg::attr_t     obj_attr;
    obj_pkg::hpos_t     obj_hpos;
    obj_pkg::bank_t     obj_bank;
    logic               start0, start1, idle0, idle1;
    obj_pkg::rom_addr_t req_addr0, req_addr1;
    obj_pkg::bank_t     req_bank0, req_bank1;
    logic               req_half0, req_half1, req_cs0, req_cs1;
    obj_pkg::rom_data_t grant_data0, grant_data1;
    logic               grant_ok0, grant_ok1;
    logic               wr0, wr1;
    obj_pkg::hpos_t     wa0, wa1;
    obj_pkg::pxl_t      wd0, wd1;

    obj_table u_table (
        .clk(clk), .rst(rst), .tbl_we(tbl_we), .tbl_addr(tbl_addr), .tbl_data(tbl_data),
        .scn_addr(scn_addr), .scn_data(scn_data)
    );

    obj_scan u_scan (
        .clk(clk), .rst(rst), .line_start(line_start), .line(line),
        .scn_addr(scn_addr), .scn_data(scn_data),
        .obj_code(obj_code), .obj_attr(obj_attr), .obj_hpos(obj_hpos), .obj_bank(obj_bank),
        .start0(start0), .start1(start1), .idle0(idle0), .idle1(idle1),
        .line_done(line_done)
    );

    obj_draw u_draw0 (
        .clk(clk), .rst(rst),
        .obj_code(obj_code), .obj_attr(obj_attr), .obj_hpos(obj_hpos), .obj_bank(obj_bank),
        .start(start0), .idle(idle0), .buf_addr(wa0), .buf_data(wd0), .buf_wr(wr0),
        .rom_addr(req_addr0), .rom_bank(req_bank0), .rom_half(req_half0),
        .rom_data(grant_data0), .rom_cs(req_cs0), .rom_ok(grant_ok0)
    );

    obj_draw u_draw1 (
        .clk(clk), .rst(rst),
        .obj_code(obj_code), .obj_attr(obj_attr), .obj_hpos(obj_hpos), .obj_bank(obj_bank),
        .start(start1), .idle(idle1), .buf_addr(wa1), .buf_data(wd1), .buf_wr(wr1),
        .rom_addr(req_addr1), .rom_bank(req_bank1), .rom_half(req_half1),
        .rom_data(grant_data1), .rom_cs(req_cs1), .rom_ok(grant_ok1)
    );

    gfx_rom_arb u_arb (
        .clk(clk), .rst(rst),
        .req_cs0(req_cs0), .req_addr0(req_addr0), .req_bank0(req_bank0), .req_half0(req_half0),
        .req_cs1(req_cs1), .req_addr1(req_addr1), .req_bank1(req_bank1), .req_half1(req_half1),
        .grant_data0(grant_data0), .grant_ok0(grant_ok0),
        .grant_data1(grant_data1), .grant_ok1(grant_ok1),
        .rom_addr(rom_addr), .rom_bank(rom_bank), .rom_half(rom_half), .rom_cs(rom_cs),
        .rom_data(rom_data), .rom_ok(rom_ok)
    );

    obj_line_buf u_buf (
        .clk(clk), .rst(rst),
        .wr0(wr0), .wa0(wa0), .wd0(wd0), .wr1(wr1), .wa1(wa1), .wd1(wd1),
        .rd_en(rd_en), .rd_addr(rd_addr), .rd_data(rd_data)
    );

endmodule

// ==== design/obj_scan.sv ====
// per-line object scanner that picks visible table entries and issues them to a free draw engine
`timescale 1ns/1ns
module obj_scan (
    input  logic                clk,
    input  logic                rst,
    input  logic                line_start,
    input  obj_pkg::vpos_t      line,
    output obj_pkg::tbl_addr_t  scn_addr,
    input  obj_pkg::word_t      scn_data,
    output obj_pkg::code_t      obj_code,
    output obj_pkg::attr_t      obj_attr,
    output obj_pkg::hpos_t      obj_hpos,
    output obj_pkg::bank_t      obj_bank,
    output logic                start0,
    output logic                start1,
    input  logic                idle0,
    input  logic                idle1,
    output logic                line_done
);

    obj_pkg::scan_state_t state;
    logic [4:0]     idx;        // table entry
    logic [1:0]     word;       // word within entry
    obj_pkg::vpos_t line_r;
    obj_pkg::vpos_t vpos_r;
    obj_pkg::vpos_t row;
    logic           scan_end;   // table walk finished
    logic           last;
    logic           end_mark;
    logic           hit;
    logic           issue;
    logic           advance;

    assign scn_addr = {idx, word};
    assign row      = line_r - vpos_r;  // lines above the object wrap high and miss
    assign last     = idx == 5'(obj_pkg::OBJ_MAX - 1);
    assign end_mark = scn_data == obj_pkg::TBL_END_ATTR;  // attr word is on scn_data in TEST
    assign hit      = row < 9'd16 && obj_hpos > obj_pkg::HPOS_MIN
                      && obj_hpos < obj_pkg::HPOS_MAX;
    assign issue    = state == obj_pkg::SCAN_ISSUE || state == obj_pkg::SCAN_WAIT;

    // engine 0 has priority over engine 1
    assign start0 = issue && idle0;
    assign start1 = issue && !idle0 && idle1;

    // skip a miss or move on once the object has gone out
    assign advance = (state == obj_pkg::SCAN_TEST && !end_mark && !hit)
                     || (issue && (idle0 || idle1));

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state     <= obj_pkg::SCAN_IDLE;
            idx       <= '0;
            word      <= '0;
            line_r    <= '0;
            scan_end  <= 1'b0;
            line_done <= 1'b0;
        end else if (line_start) begin
            state     <= obj_pkg::SCAN_RD;  // restart from entry 0
            idx       <= '0;
            word      <= '0;
            line_r    <= line;
            scan_end  <= 1'b0;
            line_done <= 1'b0;
        end else begin
            if (scan_end && idle0 && idle1) begin
                line_done <= 1'b1;  // held until next line_start
            end
            case (state)
                obj_pkg::SCAN_RD: begin
                    word <= word + 2'd1;  // wraps back to 0
                    if (word == 2'd3) begin
                        state <= obj_pkg::SCAN_TEST;
                    end
                end
                obj_pkg::SCAN_TEST: begin
                    if (end_mark) begin
                        state    <= obj_pkg::SCAN_IDLE;
                        scan_end <= 1'b1;
                    end else if (hit) begin
                        state <= obj_pkg::SCAN_ISSUE;
                    end
                end
                obj_pkg::SCAN_ISSUE, obj_pkg::SCAN_WAIT: begin
                    state <= obj_pkg::SCAN_WAIT;  // back-pressure until advance overrides
                end
                default: ;
            endcase
            if (advance) begin
                if (last) begin
                    state    <= obj_pkg::SCAN_IDLE;
                    scan_end <= 1'b1;
                end else begin
                    idx   <= idx + 5'd1;
                    state <= obj_pkg::SCAN_RD;
                end
            end
        end
    end

    // scn_data lags scn_addr by one cycle
    always_ff @(posedge clk) begin
        if (state == obj_pkg::SCAN_RD) begin
            case (word)
                2'd1: obj_hpos <= scn_data[8:0];
                2'd2: vpos_r   <= scn_data[8:0];
                2'd3: obj_code <= scn_data;
                default: ;
            endcase
        end
        if (state == obj_pkg::SCAN_TEST) begin
            obj_attr <= {scn_data[15:12], row[3:0], scn_data[7:0]};  // row into 11:8
            obj_bank <= scn_data[14:13];
        end
    end

    // the chosen engine takes the object on the start edge
    a_start0_taken: assert property (@(posedge clk) disable iff (rst) start0 |=> !idle0);
    a_start1_taken: assert property (@(posedge clk) disable iff (rst) start1 |=> !idle1);

endmodule

// ==== design/obj_table.sv ====
// object table memory written by the host four words per object and read back registered by the scanner
`timescale 1ns/1ns
module obj_table (
    input  logic                clk,
    input  logic                rst,
    input  logic                tbl_we,
    input  obj_pkg::tbl_addr_t  tbl_addr,
    input  obj_pkg::word_t      tbl_data,
    input  obj_pkg::tbl_addr_t  scn_addr,
    output obj_pkg::word_t      scn_data
);

    // entry n holds words 4n to 4n+3
    obj_pkg::word_t mem [obj_pkg::TBL_DEPTH];

    always_ff @(posedge clk) begin
        if (tbl_we) begin
            mem[tbl_addr] <= tbl_data;  // word 0 hpos, 1 vpos, 2 code, 3 attr
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            scn_data <= '0;
        end else begin
            scn_data <= mem[scn_addr];  // one cycle read latency
        end
    end

endmodule

// ==== run.sh ====
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 --top-module tb_obj_render -f src.f

./obj_dir/Vtb_obj_render | tee sim.log

if grep -qF -- '** PASS **' sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi

// ==== src.f ====
design/obj_pkg.sv
design/obj_table.sv
design/obj_scan.sv
design/obj_draw.sv
design/gfx_rom_arb.sv
design/obj_line_buf.sv
design/obj_render_top.sv
tb/obj_tb_model.sv
tb/tb_obj_render.sv

// ==== tb/obj_tb_model.sv ====
// graphics rom model for the sprite renderer testbench, fixed latency read port and word content function
`timescale 1ns/1ns
module gfx_rom_model (
    input  logic                clk,
    input  logic                rst,
    input  obj_pkg::rom_addr_t  rom_addr,
    input  obj_pkg::bank_t      rom_bank,
    input  logic                rom_half,
    input  logic                rom_cs,
    output obj_pkg::rom_data_t  rom_data,
    output logic                rom_ok
);

    logic [22:0] key;        // {bank, half, addr}
    logic [22:0] last_key;
    logic [1:0]  wait_cnt;

    // content of one rom word, also used by the line reference
    function automatic obj_pkg::rom_data_t rom_word(input obj_pkg::bank_t bank,
            input obj_pkg::rom_addr_t addr, input logic half);
        logic [31:0] seed_word;
        logic [31:0] mix;
        seed_word = {9'd0, half, bank, addr};
        mix = seed_word * 32'h9E3779B1;        // spread the address bits
        mix = mix ^ (mix >> 13) ^ (mix << 7);
        if (addr[19:16] == 4'hB && half) begin
            mix = '1;                          // code Bxxx, right half blank
        end else if (addr[19:16] == 4'hC) begin
            mix = mix | 32'h0F0F0F0F;          // code Cxxx, every other pixel colour 15
        end
        return mix;
    endfunction

    assign key = {rom_bank, rom_half, rom_addr};

    // ok after 3 cycles of a stable request, dropped on any address change
    always @(posedge clk or posedge rst) begin
        if (rst) begin
            last_key <= '0;
            wait_cnt <= '0;
            rom_ok   <= 1'b0;
            rom_data <= '0;
        end else begin
            last_key <= key;
            if (!rom_cs || key != last_key) begin
                wait_cnt <= 2'd0;
                rom_ok   <= 1'b0;
            end else if (wait_cnt == 2'd2) begin
                rom_ok   <= 1'b1;
                rom_data <= rom_word(rom_bank, rom_addr, rom_half);
            end else begin
                wait_cnt <= wait_cnt + 2'd1;
            end
        end
    end

endmodule

// ==== tb/tb_obj_render.sv ====
// sprite line renderer testbench that writes object tables, runs lines and checks every pixel
`timescale 1ns/1ns
module tb_obj_render;

    localparam int DONE_TIMEOUT = 5000;  // cycles per line

    logic               clk;
    logic               rst;
    logic               tbl_we;
    obj_pkg::tbl_addr_t tbl_addr;
    obj_pkg::word_t     tbl_data;
    logic               line_start;
    obj_pkg::vpos_t     line;
    logic               line_done;
    logic               rd_en;
    obj_pkg::hpos_t     rd_addr;
    obj_pkg::pxl_t      rd_data;
    obj_pkg::rom_addr_t rom_addr;
    obj_pkg::bank_t     rom_bank;
    logic               rom_half;
    logic               rom_cs;
    obj_pkg::rom_data_t rom_data;
    logic               rom_ok;

    obj_pkg::word_t     tbl_copy [obj_pkg::OBJ_MAX][4];  // host view of the table
    obj_pkg::vpos_t     cur_line;
    integer             seed;
    int                 checks;
    int                 errors;
    int                 timeouts;
    logic               rd_chk = 1'b0;   // rd_data due this edge
    obj_pkg::hpos_t     rd_chk_addr;

    obj_render_top u_obj_render_top (
        .clk(clk), .rst(rst), .tbl_we(tbl_we), .tbl_addr(tbl_addr), .tbl_data(tbl_data),
        .line_start(line_start), .line(line), .line_done(line_done),
        .rd_en(rd_en), .rd_addr(rd_addr), .rd_data(rd_data),
        .rom_addr(rom_addr), .rom_bank(rom_bank), .rom_half(rom_half), .rom_cs(rom_cs),
        .rom_data(rom_data), .rom_ok(rom_ok)
    );

    gfx_rom_model u_rom (
        .clk(clk), .rst(rst), .rom_addr(rom_addr), .rom_bank(rom_bank),
        .rom_half(rom_half), .rom_cs(rom_cs), .rom_data(rom_data), .rom_ok(rom_ok)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;  // 4 ns period
    end

    // expected pixel at column x of cur_line where later entries overwrite earlier ones
    function automatic obj_pkg::pxl_t expected_pixel(input obj_pkg::hpos_t x);
        obj_pkg::pxl_t      px;
        obj_pkg::vpos_t     row;
        obj_pkg::hpos_t     hp;
        obj_pkg::hpos_t     off;
        obj_pkg::word_t     attr;
        obj_pkg::rom_data_t w;
        logic [3:0]         colour;
        int                 p;
        px = '1;  // nothing drawn reads as transparent
        for (int i = 0; i < obj_pkg::OBJ_MAX; i++) begin
            attr = tbl_copy[i][3];
            if (attr == obj_pkg::TBL_END_ATTR) begin
                break;
            end
            hp  = tbl_copy[i][0][8:0];
            row = cur_line - tbl_copy[i][1][8:0];  // negative wraps high
            off = x - hp;
            if (row < 9'd16 && off < 9'd16 && hp > 9'h30 && hp < 9'h1C0) begin
                // flip swaps the halves and reads each from its low nibble
                w = u_rom.rom_word(attr[14:13], {tbl_copy[i][2], row[3:0]}, off[3] ^ attr[5]);
                p = int'(off[2:0]);
                colour = attr[5] ? w[4 * p +: 4] : w[28 - 4 * p +: 4];
                if (colour != 4'hF) begin
                    px = {attr[4:0], colour};
                end
            end
        end
        return px;
    endfunction

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAIL %0t %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    // rd_data holds the entry read on the previous edge
    always @(posedge clk) begin
        if (rd_chk) begin
            check($sformatf("rd_data[%0d]", rd_chk_addr), {23'd0, rd_data},
                  {23'd0, expected_pixel(rd_chk_addr)});
        end
        rd_chk      <= rd_en && !rst;
        rd_chk_addr <= rd_addr;
    end

    task automatic write_word(input obj_pkg::tbl_addr_t a, input obj_pkg::word_t d);
        @(posedge clk);
        tbl_we   <= 1'b1;
        tbl_addr <= a;
        tbl_data <= d;
    endtask

    task automatic write_obj(input int idx, input obj_pkg::word_t hpos, input obj_pkg::word_t vpos,
                             input obj_pkg::word_t code, input obj_pkg::word_t attr);
        tbl_copy[idx][0] = hpos;
        tbl_copy[idx][1] = vpos;
        tbl_copy[idx][2] = code;
        tbl_copy[idx][3] = attr;
        write_word(obj_pkg::tbl_addr_t'(idx * 4), hpos);
        write_word(obj_pkg::tbl_addr_t'(idx * 4 + 1), vpos);
        write_word(obj_pkg::tbl_addr_t'(idx * 4 + 2), code);
        write_word(obj_pkg::tbl_addr_t'(idx * 4 + 3), attr);
        @(posedge clk);
        tbl_we <= 1'b0;
    endtask

    task automatic write_end(input int idx);
        write_obj(idx, 16'h0, 16'h0, 16'h0, obj_pkg::TBL_END_ATTR);
    endtask

    // whole line scan-out with the compare process one cycle behind
    task automatic read_line();
        for (int a = 0; a < obj_pkg::LINE_LEN; a++) begin
            @(posedge clk);
            rd_en   <= 1'b1;
            rd_addr <= obj_pkg::hpos_t'(a);
        end
        @(posedge clk);
        rd_en <= 1'b0;
        repeat (2) @(posedge clk);
    endtask

    task automatic run_line(input obj_pkg::vpos_t n);
        int cyc;
        @(posedge clk);
        line_start <= 1'b1;
        line       <= n;
        cur_line    = n;
        @(posedge clk);
        line_start <= 1'b0;
        cyc = 0;
        do begin
            @(posedge clk);  // first sample sees line_done cleared
            cyc++;
        end while (!line_done && cyc < DONE_TIMEOUT);
        if (!line_done) begin
            $display("timeout, line_done never rose on line %0d", n);
            timeouts++;
        end else begin
            check("rom_cs", {31'd0, rom_cs}, 32'd0);  // port released with both engines idle
        end
        read_line();
    endtask

    // 32 entries with two in three on line n in their own 18-pixel slots
    task automatic fill_random(input obj_pkg::vpos_t n);
        logic [31:0]    r;
        logic [31:0]    r2;
        obj_pkg::hpos_t hp;
        obj_pkg::vpos_t vp;
        int             slot;
        slot = 0;
        for (int i = 0; i < obj_pkg::OBJ_MAX; i++) begin
            r  = $random(seed);
            r2 = $random(seed);
            if (i % 3 != 2) begin
                hp = 9'(9'h31 + slot * 18 + (r & 1));
                vp = n - {5'd0, r[7:4]};              // row 0 to 15
                slot++;
            end else begin
                hp = r[24:16];                        // anywhere since it is never drawn
                vp = n + 9'd20 + {3'd0, r[13:8]};     // below the line
            end
            write_obj(i, {7'd0, hp}, {7'd0, vp}, r2[15:0],
                      {1'b0, r[21:20], 1'b0, 4'h0, 2'b00, r[22], r[28:24]});
        end
    endtask

    initial begin
        rst        = 1'b1;
        tbl_we     = 1'b0;
        tbl_addr   = '0;
        tbl_data   = '0;
        line_start = 1'b0;
        line       = '0;
        rd_en      = 1'b0;
        rd_addr    = '0;
        cur_line   = '0;
        seed       = 15;
        checks     = 0;
        errors     = 0;
        timeouts   = 0;
        repeat (4) @(posedge clk);
        rst <= 1'b0;

        // plain object on every row plus one line above and below
        write_obj(0, 16'h040, 16'd100, 16'h1234, 16'h2003);
        write_end(1);
        for (int l = 99; l <= 116; l++) begin
            run_line(obj_pkg::vpos_t'(l));
        end

        // same object flipped
        write_obj(0, 16'h040, 16'd100, 16'h1234, 16'h2023);
        run_line(9'd100);
        run_line(9'd108);

        // blank halves and colour 15 pixels with the flipped blank half first
        write_obj(0, 16'h080, 16'd50, 16'hB123, 16'h0007);
        write_obj(1, 16'h0A0, 16'd50, 16'hC456, 16'h4029);
        write_obj(2, 16'h0C0, 16'd50, 16'hB789, 16'h6031);
        write_end(3);
        run_line(9'd50);
        run_line(9'd57);

        // hpos limits, off-line object, entry past the end marker
        write_obj(0, 16'h030, 16'd70, 16'h1111, 16'h0001);
        write_obj(1, 16'h1C0, 16'd70, 16'h2222, 16'h0002);
        write_obj(2, 16'h020, 16'd70, 16'h3333, 16'h0003);
        write_obj(3, 16'h100, 16'd70, 16'h4444, 16'h2004);
        write_obj(4, 16'h120, 16'd90, 16'h5555, 16'h0005);
        write_end(5);
        write_obj(6, 16'h140, 16'd70, 16'h6666, 16'h0006);
        run_line(9'd75);

        // full table keeps both engines and the arbiter busy
        fill_random(9'd200);
        run_line(9'd200);
        run_line(9'd400);  // empty line where leftovers would show
        run_line(9'd200);

        $display("checks %0d errors %0d timeouts %0d", checks, errors, timeouts);
        if (errors == 0 && timeouts == 0 && checks > 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule
